/* hdl/fpu_pkg.sv */
package fpu_pkg;

    // word and function code widths
    localparam int LEN_WORD  = 32;
    localparam int LEN_FUNC3 = 3;
    localparam int LEN_FUNC7 = 7;

    // single-precision field widths
    localparam int LEN_EXP  = 8;
    localparam int LEN_FRAC = 23;

    // func7 codes of the kept operations
    localparam logic [LEN_FUNC7-1:0] FUNC7_FSGNJ = 7'b0010000;
    localparam logic [LEN_FUNC7-1:0] FUNC7_FCOMP = 7'b1010000;
    localparam logic [LEN_FUNC7-1:0] FUNC7_FTOI  = 7'b1100000;
    localparam logic [LEN_FUNC7-1:0] FUNC7_ITOF  = 7'b1101000;
    // float register to integer register, raw bits
    localparam logic [LEN_FUNC7-1:0] FUNC7_FMVI  = 7'b1110000;
    // integer register to float register, raw bits
    localparam logic [LEN_FUNC7-1:0] FUNC7_IMVF  = 7'b1111000;

    // func3 under FUNC7_FSGNJ
    localparam logic [LEN_FUNC3-1:0] FUNC3_FSGNJ  = 3'b000;
    localparam logic [LEN_FUNC3-1:0] FUNC3_FSGNJN = 3'b001;
    localparam logic [LEN_FUNC3-1:0] FUNC3_FSGNJX = 3'b010;

    // func3 under FUNC7_FCOMP
    localparam logic [LEN_FUNC3-1:0] FUNC3_FLE = 3'b000;
    localparam logic [LEN_FUNC3-1:0] FUNC3_FLT = 3'b001;
    localparam logic [LEN_FUNC3-1:0] FUNC3_FEQ = 3'b010;

    // exponent bias and the inf/nan exponent
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    // saturation values of the signed conversion
    localparam logic [LEN_WORD-1:0] INT_MAX_WORD = 32'h7fff_ffff;
    localparam logic [LEN_WORD-1:0] INT_MIN_WORD = 32'h8000_0000;

    typedef struct packed {
        logic                sign;
        logic [LEN_EXP-1:0]  exp;
        logic [LEN_FRAC-1:0] frac;
    } float_t;

endpackage

/* hdl/fpu_unit_if.sv */
`timescale 1ns/1ps

// order/accepted/done link between dispatcher and one execution unit
interface fpu_unit_if;

    logic                           order;
    logic                           accepted;
    logic                           done;
    logic [fpu_pkg::LEN_FUNC3-1:0]  func3;
    logic [fpu_pkg::LEN_WORD-1:0]   rs1;
    logic [fpu_pkg::LEN_WORD-1:0]   rs2;
    logic [fpu_pkg::LEN_WORD-1:0]   rd;

    modport dispatch (
        output order,
        output func3,
        output rs1,
        output rs2,
        input  accepted,
        input  done,
        input  rd
    );

    modport unit (
        input  order,
        input  func3,
        input  rs1,
        input  rs2,
        output accepted,
        output done,
        output rd
    );

endinterface

/* hdl/fsgnj.sv */
`timescale 1ns/1ps

module fsgnj (
    input  logic       clk,
    input  logic       rst,
    fpu_unit_if.unit   bus
);

    fpu_pkg::float_t a;
    fpu_pkg::float_t b;
    fpu_pkg::float_t res;

    assign a = bus.rs1;
    assign b = bus.rs2;

    // single-cycle unit, clk and rst only keep the common shape
    assign bus.accepted = bus.order;
    assign bus.done     = bus.order;

    always_comb begin
        // magnitude always comes from rs1
        res = a;
        case (bus.func3)
            fpu_pkg::FUNC3_FSGNJ: begin
                res.sign = b.sign;
            end
            fpu_pkg::FUNC3_FSGNJN: begin
                res.sign = ~b.sign;
            end
            fpu_pkg::FUNC3_FSGNJX: begin
                res.sign = a.sign ^ b.sign;
            end
            default: begin
                res = '0;
            end
        endcase
    end

    assign bus.rd = res;

endmodule

/* hdl/fcomp.sv */
`timescale 1ns/1ps

module fcomp (
    input  logic       clk,
    input  logic       rst,
    fpu_unit_if.unit   bus
);

    fpu_pkg::float_t a;
    fpu_pkg::float_t b;
    logic            a_nan;
    logic            b_nan;
    logic            both_zero;
    logic            eq;
    logic            lt;
    logic            le;

    assign a = bus.rs1;
    assign b = bus.rs2;

    assign a_nan = (a.exp == fpu_pkg::LEN_EXP'(fpu_pkg::EXP_MAX)) && (a.frac != '0);
    assign b_nan = (b.exp == fpu_pkg::LEN_EXP'(fpu_pkg::EXP_MAX)) && (b.frac != '0);

    // +0 and -0 are the same number
    assign both_zero = ({a.exp, a.frac} == '0) && ({b.exp, b.frac} == '0);

    always_comb begin
        eq = (a == b) || both_zero;
        if (both_zero) begin
            lt = 1'b0;
        end else if (a.sign != b.sign) begin
            // negative side is the smaller one
            lt = a.sign;
        end else if (a.sign) begin
            lt = {a.exp, a.frac} > {b.exp, b.frac};
        end else begin
            lt = {a.exp, a.frac} < {b.exp, b.frac};
        end
        le = lt | eq;
        // unordered compares are all false
        if (a_nan || b_nan) begin
            eq = 1'b0;
            lt = 1'b0;
            le = 1'b0;
        end
    end

    always_comb begin
        bus.rd = '0;
        case (bus.func3)
            fpu_pkg::FUNC3_FEQ: bus.rd[0] = eq;
            fpu_pkg::FUNC3_FLT: bus.rd[0] = lt;
            fpu_pkg::FUNC3_FLE: bus.rd[0] = le;
            default:            bus.rd    = '0;
        endcase
    end

    assign bus.accepted = bus.order;
    assign bus.done     = bus.order;

endmodule

/* hdl/itof.sv */
`timescale 1ns/1ps

module itof (
    input  logic       clk,
    input  logic       rst,
    fpu_unit_if.unit   bus
);

    typedef enum logic {
        IDLE,
        SHIFT
    } state_t;

    state_t                       state;
    logic [fpu_pkg::LEN_WORD-1:0] mag;
    logic                         sign_q;
    logic [4:0]                   count;
    logic                         finish;
    fpu_pkg::float_t              res;

    // orders arriving mid-conversion are ignored
    assign bus.accepted = bus.order && (state == IDLE);

    // normalized, or nothing to normalize
    assign finish   = (state == SHIFT) && (mag[fpu_pkg::LEN_WORD-1] || (mag == '0));
    assign bus.done = finish;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (bus.order) begin
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (finish) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.accepted) begin
            // magnitude of INT_MIN is still 2^31 unsigned
            mag    <= bus.rs1[fpu_pkg::LEN_WORD-1] ? -bus.rs1 : bus.rs1;
            sign_q <= bus.rs1[fpu_pkg::LEN_WORD-1];
            count  <= '0;
        end else if ((state == SHIFT) && !finish) begin
            mag   <= mag << 1;
            count <= count + 5'd1;
        end
    end

    always_comb begin
        res.sign = sign_q;
        res.exp  = fpu_pkg::LEN_EXP'(fpu_pkg::EXP_BIAS + 31 - int'(count));
        // bits below the leading one, truncated
        res.frac = mag[fpu_pkg::LEN_WORD-2 -: fpu_pkg::LEN_FRAC];
    end

    assign bus.rd = (mag == '0) ? '0 : res;

endmodule

/* hdl/ftoi.sv */
`timescale 1ns/1ps

module ftoi (
    input  logic       clk,
    input  logic       rst,
    fpu_unit_if.unit   bus
);

    fpu_pkg::float_t              f;
    logic                         is_nan;
    logic [fpu_pkg::LEN_EXP-1:0]  shamt;
    logic [54:0]                  shifted;
    logic [fpu_pkg::LEN_WORD-1:0] mag;

    assign f = bus.rs1;

    assign is_nan = (f.exp == fpu_pkg::LEN_EXP'(fpu_pkg::EXP_MAX)) && (f.frac != '0);

    // unbiased exponent, only meaningful once exp >= bias
    assign shamt = f.exp - fpu_pkg::LEN_EXP'(fpu_pkg::EXP_BIAS);

    // mantissa with hidden one, binary point sits at bit 23
    assign shifted = {31'b0, 1'b1, f.frac} << shamt;
    assign mag     = shifted[54:fpu_pkg::LEN_FRAC];

    always_comb begin
        if (is_nan) begin
            bus.rd = fpu_pkg::INT_MAX_WORD;
        end else if (f.exp < fpu_pkg::LEN_EXP'(fpu_pkg::EXP_BIAS)) begin
            // |x| < 1 truncates to zero
            bus.rd = '0;
        end else if (shamt >= 8'd31) begin
            // out of range or infinity, -2^31 lands here too
            bus.rd = f.sign ? fpu_pkg::INT_MIN_WORD : fpu_pkg::INT_MAX_WORD;
        end else begin
            bus.rd = f.sign ? -mag : mag;
        end
    end

    assign bus.accepted = bus.order;
    assign bus.done     = bus.order;

endmodule

/* hdl/fpu.sv */
`timescale 1ns/1ps

module fpu (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           order,
    output logic                           accepted,
    output logic                           done,
    input  logic [fpu_pkg::LEN_FUNC3-1:0]  func3,
    input  logic [fpu_pkg::LEN_FUNC7-1:0]  func7,
    input  logic [fpu_pkg::LEN_WORD-1:0]   rs1,
    input  logic [fpu_pkg::LEN_WORD-1:0]   rs2,
    output logic [fpu_pkg::LEN_WORD-1:0]   rd
);

    logic                         busy;
    logic                         order_able;
    logic                         fmvi_order;
    logic                         imvf_order;
    logic                         error_order;
    logic [fpu_pkg::LEN_WORD-1:0] rd_hold;
    logic [fpu_pkg::LEN_WORD-1:0] rd_now;

    fpu_unit_if sgnj_bus ();
    fpu_unit_if comp_bus ();
    fpu_unit_if itof_bus ();
    fpu_unit_if ftoi_bus ();

    // orders go out only while no unit is working
    assign order_able = order & ~busy;

    // operands fan out to every unit untouched
    assign sgnj_bus.rs1   = rs1;
    assign sgnj_bus.rs2   = rs2;
    assign sgnj_bus.func3 = func3;
    assign comp_bus.rs1   = rs1;
    assign comp_bus.rs2   = rs2;
    assign comp_bus.func3 = func3;
    assign itof_bus.rs1   = rs1;
    assign itof_bus.rs2   = rs2;
    assign itof_bus.func3 = func3;
    assign ftoi_bus.rs1   = rs1;
    assign ftoi_bus.rs2   = rs2;
    assign ftoi_bus.func3 = func3;

    // func7 decode, one order at most
    assign sgnj_bus.order = order_able & (func7 == fpu_pkg::FUNC7_FSGNJ);
    assign comp_bus.order = order_able & (func7 == fpu_pkg::FUNC7_FCOMP);
    assign itof_bus.order = order_able & (func7 == fpu_pkg::FUNC7_ITOF);
    assign ftoi_bus.order = order_able & (func7 == fpu_pkg::FUNC7_FTOI);
    assign fmvi_order     = order_able & (func7 == fpu_pkg::FUNC7_FMVI);
    assign imvf_order     = order_able & (func7 == fpu_pkg::FUNC7_IMVF);

    // anything unknown completes at once with zero
    assign error_order = order_able &
                         (func7 != fpu_pkg::FUNC7_FSGNJ) &
                         (func7 != fpu_pkg::FUNC7_FCOMP) &
                         (func7 != fpu_pkg::FUNC7_ITOF) &
                         (func7 != fpu_pkg::FUNC7_FTOI) &
                         (func7 != fpu_pkg::FUNC7_FMVI) &
                         (func7 != fpu_pkg::FUNC7_IMVF);

    fsgnj fsgnj_i (.clk(clk), .rst(rst), .bus(sgnj_bus));
    fcomp fcomp_i (.clk(clk), .rst(rst), .bus(comp_bus));
    itof  itof_i  (.clk(clk), .rst(rst), .bus(itof_bus));
    ftoi  ftoi_i  (.clk(clk), .rst(rst), .bus(ftoi_bus));

    // moves and illegal codes accept and finish in the order cycle
    assign accepted = sgnj_bus.accepted | comp_bus.accepted | itof_bus.accepted |
                      ftoi_bus.accepted | fmvi_order | imvf_order | error_order;
    assign done     = sgnj_bus.done | comp_bus.done | itof_bus.done |
                      ftoi_bus.done | fmvi_order | imvf_order | error_order;

    // result of whoever finishes, else the last one kept
    always_comb begin
        if (sgnj_bus.done) begin
            rd_now = sgnj_bus.rd;
        end else if (comp_bus.done) begin
            rd_now = comp_bus.rd;
        end else if (itof_bus.done) begin
            rd_now = itof_bus.rd;
        end else if (ftoi_bus.done) begin
            rd_now = ftoi_bus.rd;
        end else if (fmvi_order | imvf_order) begin
            rd_now = rs1;
        end else if (error_order) begin
            rd_now = '0;
        end else begin
            rd_now = rd_hold;
        end
    end

    assign rd = rd_now;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            rd_hold <= '0;
        end else begin
            // set by a multi-cycle accept, dropped when its done shows
            busy <= ~done & (busy | accepted);
            if (done) begin
                rd_hold <= rd_now;
            end
        end
    end

endmodule

/* testbench/fpu_tb.sv */
`timescale 1ns/1ps

module fpu_tb;

    localparam int TIMEOUT = 100;

    logic                          clk;
    logic                          rst;
    logic                          order;
    logic                          accepted;
    logic                          done;
    logic [fpu_pkg::LEN_FUNC3-1:0] func3;
    logic [fpu_pkg::LEN_FUNC7-1:0] func7;
    logic [fpu_pkg::LEN_WORD-1:0]  rs1;
    logic [fpu_pkg::LEN_WORD-1:0]  rs2;
    logic [fpu_pkg::LEN_WORD-1:0]  rd;

    int          check_count    = 0;
    int          mismatch_count = 0;
    int          timeout_count  = 0;
    logic [15:0] lfsr_state     = 16'd11926;

    fpu fpu_i (
        .clk(clk), .rst(rst), .order(order), .accepted(accepted), .done(done),
        .func3(func3), .func7(func7), .rs1(rs1), .rs2(rs2), .rd(rd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], next_bit()};
        end
        return w;
    endfunction

    function automatic logic [31:0] sgnj_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            fpu_pkg::FUNC3_FSGNJ:  return {b[31], a[30:0]};
            fpu_pkg::FUNC3_FSGNJN: return {~b[31], a[30:0]};
            fpu_pkg::FUNC3_FSGNJX: return {a[31] ^ b[31], a[30:0]};
            default:               return '0;
        endcase
    endfunction

    // signed view of sign-magnitude maps -0 and +0 both to 0
    function automatic logic [31:0] cmp_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        logic signed [32:0] va;
        logic signed [32:0] vb;
        logic               nan;
        logic               r;
        nan = ((a[30:23] == 8'hff) && (a[22:0] != 0)) || ((b[30:23] == 8'hff) && (b[22:0] != 0));
        va = a[31] ? -$signed({2'b00, a[30:0]}) : $signed({2'b00, a[30:0]});
        vb = b[31] ? -$signed({2'b00, b[30:0]}) : $signed({2'b00, b[30:0]});
        case (f3)
            fpu_pkg::FUNC3_FLE: r = (va <= vb);
            fpu_pkg::FUNC3_FLT: r = (va < vb);
            fpu_pkg::FUNC3_FEQ: r = (va == vb);
            default:            r = 1'b0;
        endcase
        if (nan) begin
            r = 1'b0;
        end
        return {31'b0, r};
    endfunction

    function automatic logic [31:0] itof_model(logic [31:0] x);
        logic [31:0] mag;
        logic [31:0] norm;
        int          p;
        if (x == 0) begin
            return '0;
        end
        mag = x[31] ? -x : x;
        p = 31;
        while (!mag[p]) begin
            p--;
        end
        // leading one moves to bit 31 and the fraction follows it
        norm = mag << (31 - p);
        return {x[31], 8'(fpu_pkg::EXP_BIAS + p), norm[30:8]};
    endfunction

    function automatic logic [31:0] ftoi_model(logic [31:0] f);
        logic [31:0] mag;
        int          e;
        if ((f[30:23] == 8'hff) && (f[22:0] != 0)) begin
            return fpu_pkg::INT_MAX_WORD;
        end
        e = int'(f[30:23]) - fpu_pkg::EXP_BIAS;
        if (e < 0) begin
            return '0;
        end
        if (e >= 31) begin
            return f[31] ? fpu_pkg::INT_MIN_WORD : fpu_pkg::INT_MAX_WORD;
        end
        if (e >= 23) begin
            mag = {8'b0, 1'b1, f[22:0]} << (e - 23);
        end else begin
            mag = {8'b0, 1'b1, f[22:0]} >> (23 - e);
        end
        return f[31] ? -mag : mag;
    endfunction

    task automatic check(input string name, input logic [31:0] want, input logic [31:0] got);
        check_count++;
        if (want !== got) begin
            $display("[ERROR] %s: expected %h, actual %h", name, want, got);
            mismatch_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        timeout_count++;
    endtask

    // lat counts cycles from acceptance to done
    task automatic run_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input logic [31:0] a, input logic [31:0] b,
                          output logic [31:0] res, output int lat);
        int   waited;
        logic seen_done;
        res = '0;
        lat = -1;
        seen_done = 1'b0;
        waited = 0;
        @(posedge clk);
        order <= 1'b1;
        func7 <= f7;
        func3 <= f3;
        rs1   <= a;
        rs2   <= b;
        @(negedge clk);
        while (!accepted && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!accepted) begin
            report_timeout($sformatf("%s was never accepted", name));
            @(posedge clk);
            order <= 1'b0;
        end else begin
            if (done) begin
                seen_done = 1'b1;
                res = rd;
                lat = 0;
            end
            @(posedge clk);
            order <= 1'b0;
            waited = 0;
            while (!seen_done && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
                if (done) begin
                    seen_done = 1'b1;
                    res = rd;
                    lat = waited;
                end
            end
            if (!seen_done) begin
                report_timeout($sformatf("%s was accepted but never finished", name));
            end
        end
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        check("accepted after reset", 0, accepted);
        check("done after reset", 0, done);
        check("rd after reset", 0, rd);
    endtask

    task automatic sign_injection();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [2:0]  codes [4];
        int          lat;
        codes[0] = fpu_pkg::FUNC3_FSGNJ;
        codes[1] = fpu_pkg::FUNC3_FSGNJN;
        codes[2] = fpu_pkg::FUNC3_FSGNJX;
        codes[3] = 3'b111;
        for (int i = 0; i < 8; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            for (int k = 0; k < 4; k++) begin
                run_op("fsgnj", fpu_pkg::FUNC7_FSGNJ, codes[k], a, b, res, lat);
                check($sformatf("fsgnj func3=%0d", codes[k]), sgnj_model(codes[k], a, b), res);
                check("fsgnj latency", 0, lat);
            end
        end
    endtask

    task automatic comparisons();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] pairs [$];
        logic [2:0]  codes [4];
        int          lat;
        codes[0] = fpu_pkg::FUNC3_FLE;
        codes[1] = fpu_pkg::FUNC3_FLT;
        codes[2] = fpu_pkg::FUNC3_FEQ;
        codes[3] = 3'b111;
        // signed zeros and quiet nans go first
        pairs = {32'h0000_0000, 32'h8000_0000, 32'h7fc0_0000, 32'h3f80_0000,
                 32'hc000_0000, 32'hffc0_0123};
        for (int i = 0; i < 8; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            pairs.push_back(a);
            pairs.push_back(b);
            pairs.push_back(a);
            pairs.push_back(a);
        end
        for (int i = 0; i + 1 < pairs.size(); i += 2) begin
            for (int k = 0; k < 4; k++) begin
                run_op("fcomp", fpu_pkg::FUNC7_FCOMP, codes[k], pairs[i], pairs[i+1], res, lat);
                check($sformatf("fcomp func3=%0d %h %h", codes[k], pairs[i], pairs[i+1]),
                      cmp_model(codes[k], pairs[i], pairs[i+1]), res);
                check("fcomp latency", 0, lat);
            end
        end
    endtask

    task automatic conversions_from_int();
        logic [31:0] vals [$];
        logic [31:0] res;
        int          lat;
        vals = {32'd0, 32'd1, 32'hffff_ffff, fpu_pkg::INT_MIN_WORD};
        for (int i = 0; i < 8; i++) begin
            vals.push_back(rand_bits(32));
        end
        foreach (vals[i]) begin
            run_op("itof", fpu_pkg::FUNC7_ITOF, 3'b000, vals[i], 32'h0, res, lat);
            check($sformatf("itof %h", vals[i]), itof_model(vals[i]), res);
            check("itof latency within 1 to 32", 1, (lat >= 1) && (lat <= 32));
        end
    endtask

    task automatic conversions_to_int();
        logic [31:0] vals [$];
        logic [31:0] w;
        logic [31:0] res;
        logic [7:0]  e8;
        int          lat;
        // 1.0, -2.5, 0.75, -0.5, +-1e10, +-inf, two nans
        vals = {32'h3f80_0000, 32'hc020_0000, 32'h3f40_0000, 32'hbf00_0000,
                32'h5015_02f9, 32'hd015_02f9, 32'h7f80_0000, 32'hff80_0000,
                32'h7fc0_0000, 32'hffc0_0001};
        for (int i = 0; i < 12; i++) begin
            // exponents from 2^0 to 2^31 cover both range and saturation
            w = rand_bits(29);
            e8 = 8'(fpu_pkg::EXP_BIAS) + {3'b0, w[27:23]};
            vals.push_back({w[28], e8, w[22:0]});
        end
        foreach (vals[i]) begin
            run_op("ftoi", fpu_pkg::FUNC7_FTOI, 3'b000, vals[i], 32'h0, res, lat);
            check($sformatf("ftoi %h", vals[i]), ftoi_model(vals[i]), res);
            check("ftoi latency", 0, lat);
        end
    endtask

    task automatic moves();
        logic [31:0] a;
        logic [31:0] res;
        int          lat;
        a = rand_bits(32);
        run_op("fmv to int", fpu_pkg::FUNC7_FMVI, 3'b000, a, rand_bits(32), res, lat);
        check("fmv to int", a, res);
        check("fmv to int latency", 0, lat);
        @(negedge clk);
        check("rd hold after fmv to int", a, rd);
        a = rand_bits(32);
        run_op("fmv to float", fpu_pkg::FUNC7_IMVF, 3'b000, a, rand_bits(32), res, lat);
        check("fmv to float", a, res);
        check("fmv to float latency", 0, lat);
        @(negedge clk);
        check("rd hold after fmv to float", a, rd);
        run_op("illegal func7", 7'b0000011, 3'b000, rand_bits(32), rand_bits(32), res, lat);
        check("illegal func7", 0, res);
        check("illegal func7 latency", 0, lat);
        @(negedge clk);
        check("rd hold after illegal func7", 0, rd);
    endtask

    task automatic back_pressure();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] conv;
        logic        itof_done;
        int          waited;
        a = rand_bits(32);
        b = rand_bits(32);
        conv = '0;
        itof_done = 1'b0;
        waited = 0;
        @(posedge clk);
        order <= 1'b1;
        func7 <= fpu_pkg::FUNC7_ITOF;
        func3 <= 3'b000;
        rs1   <= 32'd5;
        rs2   <= 32'd0;
        @(negedge clk);
        while (!accepted && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!accepted) begin
            report_timeout("itof before back pressure was never accepted");
        end
        // next order goes up right at the accepting edge and stays up
        @(posedge clk);
        func7 <= fpu_pkg::FUNC7_FSGNJ;
        func3 <= fpu_pkg::FUNC3_FSGNJX;
        rs1   <= a;
        rs2   <= b;
        waited = 0;
        while (!itof_done && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
            check("accepted while itof busy", 0, accepted);
            if (done) begin
                itof_done = 1'b1;
                conv = rd;
            end
        end
        if (!itof_done) begin
            report_timeout("itof under back pressure never finished");
        end
        check("itof under back pressure", itof_model(32'd5), conv);
        // pending order is taken one cycle after the itof done
        @(negedge clk);
        check("pending order accepted", 1, accepted);
        check("pending order done", 1, done);
        check("pending fsgnjx", sgnj_model(fpu_pkg::FUNC3_FSGNJX, a, b), rd);
        @(posedge clk);
        order <= 1'b0;
    endtask

    initial begin
        rst   = 1'b1;
        order = 1'b0;
        func3 = '0;
        func7 = '0;
        rs1   = '0;
        rs2   = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        sign_injection();
        comparisons();
        conversions_from_int();
        conversions_to_int();
        moves();
        back_pressure();
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, mismatch_count, timeout_count);
        if ((mismatch_count == 0) && (timeout_count == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/fpu_pkg.sv
hdl/fpu_unit_if.sv
hdl/fsgnj.sv
hdl/fcomp.sv
hdl/itof.sv
hdl/ftoi.sv
hdl/fpu.sv
testbench/fpu_tb.sv

/* Bender.yml */
package:
  name: fpu

sources:
  - files:
      - hdl/fpu_pkg.sv
      - hdl/fpu_unit_if.sv
      - hdl/fsgnj.sv
      - hdl/fcomp.sv
      - hdl/itof.sv
      - hdl/ftoi.sv
      - hdl/fpu.sv
  - target: test
    files:
      - testbench/fpu_tb.sv
